// ==== compile.f ====
source/fpu_pkg.sv
source/fpu_issue_ctrl.sv
source/fpu_decode.sv
source/fpu_regfile.sv
source/fpu_execute.sv
source/fpu_top.sv
tb/fpu_tb.sv

// ==== Makefile ====
TOP = fpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/fpu_tb.sv ====
`timescale 1ns/100ps

module fpu_tb;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_MOVES  = 8;
  localparam int NUM_RAND   = 300;
  localparam int NUM_TXN    = 2 * NUM_MOVES + 15 + 10 + 4 + NUM_RAND + 5;

  // Operation codes of the stimulus
  localparam int K_SGNJ   = 0;
  localparam int K_SGNJN  = 1;
  localparam int K_SGNJX  = 2;
  localparam int K_MIN    = 3;
  localparam int K_MAX    = 4;
  localparam int K_FEQ    = 5;
  localparam int K_FLT    = 6;
  localparam int K_FLE    = 7;
  localparam int K_FCLASS = 8;
  localparam int K_F2I    = 9;
  localparam int K_I2F    = 10;
  localparam int K_FADD   = 11;
  localparam int K_FMADD  = 12;
  localparam int K_FLW    = 13;
  localparam int K_BAD    = 14;

  logic                clk;
  logic                rst_n;
  logic                req;
  fpu_pkg::fp_req_s    req_data;
  logic                ack;
  fpu_pkg::fp_result_s result;

  fpu_pkg::fp_result_s exp_res;
  logic [31:0] shadow [32];
  int errors;
  int n_txn;
  int n_results = 0;

  // +0, -0, +inf, -inf, qNaN, sNaN, +normal, -normal, +subnormal, -subnormal
  logic [31:0] specials [10] = '{32'h00000000, 32'h80000000, 32'h7f800000, 32'hff800000,
                                 32'h7fc00000, 32'h7f800001, 32'h3f800000, 32'hc0200000,
                                 32'h00000001, 32'h80400000};

  fpu_top fpu_top_inst (
    .clk        (clk),
    .rst_n_i    (rst_n),
    .req_i      (req),
    .req_data_i (req_data),
    .ack_o      (ack),
    .result_o   (result)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    if (rst_n && result.valid) n_results++;
  end

  task automatic log_error(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
  endfunction

  // Signed ordering key where both zeros map to 0
  function automatic logic signed [32:0] order_key(input logic [31:0] x);
    logic signed [32:0] mag;
    mag = {2'b00, x[30:0]};
    return x[31] ? -mag : mag;
  endfunction

  function automatic logic [9:0] class_mask(input logic [31:0] x);
    int idx;
    if (is_nan(x))                  idx = x[22] ? 9 : 8;
    else if (x[30:23] == 8'hff)     idx = x[31] ? 0 : 7;
    else if (x[30:23] != 8'h00)     idx = x[31] ? 1 : 6;
    else if (x[22:0] != 23'h0)      idx = x[31] ? 2 : 5;
    else                            idx = x[31] ? 3 : 4;
    return 10'd1 << idx;
  endfunction

  function automatic logic [31:0] pick_minmax(input logic [31:0] a, input logic [31:0] b,
                                              input logic want_min);
    logic a_lower;
    if (is_nan(a) && is_nan(b)) return 32'h7fc00000;
    if (is_nan(a)) return b;
    if (is_nan(b)) return a;
    if (order_key(a) == order_key(b)) a_lower = a[31];  // -0 below +0
    else a_lower = order_key(a) < order_key(b);
    return (a_lower == want_min) ? a : b;
  endfunction

  function automatic logic [6:0] pick_bad_opcode();
    logic [6:0] opc;
    do begin
      opc = 7'($urandom);
    end while (opc inside {fpu_pkg::OPC_FLOAD, fpu_pkg::OPC_FSTORE, fpu_pkg::OPC_FP,
                           fpu_pkg::OPC_FMADD, fpu_pkg::OPC_FMSUB, fpu_pkg::OPC_FNMSUB,
                           fpu_pkg::OPC_FNMADD});
    return opc;
  endfunction

  function automatic logic result_matches(input fpu_pkg::fp_result_s got,
                                          input fpu_pkg::fp_result_s want);
    logic flags_ok;
    flags_ok = (got.rd == want.rd) && (got.to_fp == want.to_fp)
            && (got.to_int == want.to_int) && (got.illegal == want.illegal)
            && (got.unsupported == want.unsupported);
    if (!(want.to_fp || want.to_int)) return flags_ok;
    return flags_ok && (got.data == want.data);
  endfunction

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (ack !== level && n < 20);
    if (ack !== level) begin
      errors++;
      $display("Handshake stalled: ack never reached %0b by %0t", level, $time);
    end
  endtask

  task automatic wait_result();
    int n;
    n = 0;
    while (n_results != n_txn && n < 20) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (n_results != n_txn) begin
      errors++;
      $display("No result came back for the request issued before %0t", $time);
    end
  endtask

  // One four-phase transaction with its predicted result
  task automatic do_op(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [4:0] rs2, input logic [31:0] ival);
    logic [31:0]        a;
    logic [31:0]        b;
    logic signed [32:0] ka;
    logic signed [32:0] kb;
    logic               nan_any;
    logic [4:0]         grp;
    logic [2:0]         f3;
    logic [6:0]         opc;
    logic [31:0]        d;
    int                 hold;
    a = shadow[rs1];
    b = shadow[rs2];
    ka = order_key(a);
    kb = order_key(b);
    nan_any = is_nan(a) || is_nan(b);
    case (kind)
      K_SGNJ:   {grp, f3} = {fpu_pkg::F7_FSGNJ, 3'd0};
      K_SGNJN:  {grp, f3} = {fpu_pkg::F7_FSGNJ, 3'd1};
      K_SGNJX:  {grp, f3} = {fpu_pkg::F7_FSGNJ, 3'd2};
      K_MIN:    {grp, f3} = {fpu_pkg::F7_FMINMAX, 3'd0};
      K_MAX:    {grp, f3} = {fpu_pkg::F7_FMINMAX, 3'd1};
      K_FEQ:    {grp, f3} = {fpu_pkg::F7_FCMP, 3'd2};
      K_FLT:    {grp, f3} = {fpu_pkg::F7_FCMP, 3'd1};
      K_FLE:    {grp, f3} = {fpu_pkg::F7_FCMP, 3'd0};
      K_FCLASS: {grp, f3} = {fpu_pkg::F7_FMV_F2I, 3'd1};
      K_F2I:    {grp, f3} = {fpu_pkg::F7_FMV_F2I, 3'd0};
      K_I2F:    {grp, f3} = {fpu_pkg::F7_FMV_I2F, 3'd0};
      K_FADD:   {grp, f3} = {fpu_pkg::F7_FADD, 3'd0};
      K_FLW:    {grp, f3} = {5'd0, fpu_pkg::FUNCT3_W};
      default:  {grp, f3} = {5'd4, 3'd0};  // rs3 of fmadd
    endcase
    case (kind)
      K_FMADD: opc = fpu_pkg::OPC_FMADD;
      K_FLW:   opc = fpu_pkg::OPC_FLOAD;
      K_BAD:   opc = pick_bad_opcode();
      default: opc = fpu_pkg::OPC_FP;
    endcase
    case (kind)
      K_SGNJ:   d = {b[31], a[30:0]};
      K_SGNJN:  d = {~b[31], a[30:0]};
      K_SGNJX:  d = {a[31] ^ b[31], a[30:0]};
      K_MIN:    d = pick_minmax(a, b, 1'b1);
      K_MAX:    d = pick_minmax(a, b, 1'b0);
      K_FEQ:    d = {31'b0, !nan_any && (ka == kb)};
      K_FLT:    d = {31'b0, !nan_any && (ka < kb)};
      K_FLE:    d = {31'b0, !nan_any && (ka <= kb)};
      K_FCLASS: d = {22'b0, class_mask(a)};
      K_F2I:    d = a;
      K_I2F:    d = ival;
      default:  d = '0;
    endcase
    @(posedge clk);
    #1;
    exp_res             = '0;
    exp_res.valid       = 1'b1;
    exp_res.rd          = rd;
    exp_res.data        = d;
    exp_res.to_fp       = kind inside {[K_SGNJ:K_MAX], K_I2F};
    exp_res.to_int      = kind inside {[K_FEQ:K_F2I]};
    exp_res.unsupported = kind inside {K_FADD, K_FMADD, K_FLW};
    exp_res.illegal     = (kind == K_BAD);
    req_data.instr      = {grp, 2'b00, rs2, rs1, f3, rd, opc};
    req_data.int_data   = ival;
    req = 1'b1;
    n_txn++;
    wait_ack(1'b1);
    hold = $urandom_range(1, 0);
    repeat (hold) begin  // Now and then ack has to wait in HOLD
      @(posedge clk);
      #1;
    end
    req = 1'b0;
    wait_ack(1'b0);
    wait_result();
    if (exp_res.to_fp) shadow[rd] = exp_res.data;
  endtask

  reset_idle: assert property (@(posedge clk) !rst_n |-> !ack && !result.valid)
    else log_error("ack or result valid high during reset");

  ack_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(req) |=> $rose(ack))
    else log_error("ack did not rise one cycle after req");

  ack_fall: assert property (@(posedge clk) disable iff (!rst_n) $fell(req) |=> $fell(ack))
    else log_error("ack did not fall one cycle after req");

  ack_quiet: assert property (@(posedge clk) disable iff (!rst_n) !req && !ack |=> !ack)
    else log_error("ack rose without a request");

  result_latency: assert property (@(posedge clk) disable iff (!rst_n)
    result.valid == ($past(ack, 2) && !$past(ack, 3)))
    else log_error("result valid not two cycles after ack rise");

  result_value: assert property (@(posedge clk) disable iff (!rst_n)
    result.valid |-> result_matches(result, exp_res))
    else log_error($sformatf("result %h, expected %h", $sampled(result), $sampled(exp_res)));

  initial begin
    int         kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    void'($urandom(24816));
    clk      = 1'b0;
    rst_n    = 1'b0;
    req      = 1'b0;
    req_data = '0;
    exp_res  = '0;
    errors   = 0;
    n_txn    = 0;
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);
    for (int i = 0; i < NUM_MOVES; i++) begin
      rd = 5'($urandom_range(31, 0));
      do_op(K_I2F, rd, 5'd0, 5'd0, $urandom);
      do_op(K_F2I, rd, rd, 5'd0, 32'h0);
    end
    for (int i = 1; i <= 10; i++) do_op(K_I2F, 5'(i), 5'd0, 5'd0, specials[i - 1]);
    for (int i = 11; i <= 15; i++) do_op(K_I2F, 5'(i), 5'd0, 5'd0, $urandom);
    for (int i = 1; i <= 10; i++) do_op(K_FCLASS, 5'd0, 5'(i), 5'd0, 32'h0);
    do_op(K_MIN, 5'd16, 5'd1, 5'd2, 32'h0);  // +0 against -0
    do_op(K_MAX, 5'd17, 5'd2, 5'd1, 32'h0);
    do_op(K_MIN, 5'd18, 5'd5, 5'd7, 32'h0);  // qNaN against a number
    do_op(K_FEQ, 5'd0, 5'd5, 5'd5, 32'h0);
    for (int i = 0; i < NUM_RAND; i++) begin
      kind = $urandom_range(K_FLE, K_SGNJ);
      rd   = 5'($urandom_range(31, 16));
      rs1  = 5'($urandom_range(31, 1));
      rs2  = 5'($urandom_range(31, 1));
      do_op(kind, rd, rs1, rs2, 32'h0);
    end
    do_op(K_FADD, 5'd7, 5'd2, 5'd3, 32'h0);
    do_op(K_FMADD, 5'd7, 5'd2, 5'd3, 32'h0);
    do_op(K_FLW, 5'd7, 5'd2, 5'd0, 32'h0);
    do_op(K_BAD, 5'd7, 5'd2, 5'd3, 32'h0);
    do_op(K_F2I, 5'd1, 5'd7, 5'd0, 32'h0);  // f7 must still hold +1.0
    repeat (4) @(posedge clk);
    if (n_results != n_txn) log_error($sformatf("%0d results for %0d requests", n_results, n_txn));
    $display("Summary: %0d requests, %0d results, %0d errors", n_txn, n_results, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #((NUM_TXN * 8 + 100) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", NUM_TXN * 8 + 100);
    $display("Summary: %0d requests, %0d results, %0d errors", n_txn, n_results, errors);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== source/fpu_top.sv ====
`timescale 1ns/100ps

module fpu_top (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  fpu_pkg::fp_req_s    req_data_i,
  output logic               ack_o,
  output fpu_pkg::fp_result_s result_o
);

  logic               issue;
  fpu_pkg::fp_req_s   issue_data;
  fpu_pkg::fp_ctrl_s  ctrl;
  fpu_pkg::fp_rdata_s rdata;

  fpu_issue_ctrl fpu_issue_ctrl_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .req_data_i   (req_data_i),
    .ack_o        (ack_o),
    .issue_o      (issue),
    .issue_data_o (issue_data)
  );

  fpu_decode fpu_decode_inst (
    .instr_i (issue_data),
    .valid_i (issue),
    .ctrl_o  (ctrl)
  );

  fpu_regfile fpu_regfile_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .raddr_i ({ctrl.rs3, ctrl.rs2, ctrl.rs1}),
    .rd_o    (rdata),
    .we_i    (result_o.valid && result_o.to_fp),  // Writeback at the end of W
    .waddr_i (result_o.rd),
    .wdata_i (result_o.data)
  );

  fpu_execute fpu_execute_inst (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .issue_i  (issue),
    .ctrl_i   (ctrl),
    .rd_i     (rdata),
    .result_o (result_o)
  );

endmodule

// ==== source/fpu_execute.sv ====
`timescale 1ns/100ps

module fpu_execute (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               issue_i,
  input  fpu_pkg::fp_ctrl_s   ctrl_i,
  input  fpu_pkg::fp_rdata_s  rd_i,
  output fpu_pkg::fp_result_s result_o
);

  logic                x_valid;
  fpu_pkg::fp_ctrl_s   x_ctrl;
  fpu_pkg::fp_result_s w_next;
  logic [31:0] opa;
  logic [31:0] opb;
  logic [31:0] minmax;
  logic [9:0]  fclass;
  logic        a_nan;
  logic        b_nan;
  logic        both_zero;
  logic        lt_raw;
  logic        feq;
  logic        flt;
  logic        ok;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) x_valid <= 1'b0;
    else          x_valid <= issue_i;
  end

  always_ff @(posedge clk) begin
    if (issue_i) x_ctrl <= ctrl_i;
  end

  assign opa = x_ctrl.frden1 ? rd_i.rdata1 : '0;
  assign opb = x_ctrl.frden2 ? rd_i.rdata2 : '0;

  assign a_nan     = (opa[30:23] == 8'hff) && (opa[22:0] != '0);
  assign b_nan     = (opb[30:23] == 8'hff) && (opb[22:0] != '0);
  assign both_zero = (opa[30:0] == '0) && (opb[30:0] == '0);

  always_comb begin
    if (opa[31] != opb[31]) lt_raw = opa[31] && !both_zero;
    else if (opa[31])       lt_raw = opa[30:0] > opb[30:0];  // Both negative
    else                    lt_raw = opa[30:0] < opb[30:0];
  end

  assign feq = !(a_nan || b_nan) && ((opa == opb) || both_zero);
  assign flt = !(a_nan || b_nan) && lt_raw;

  always_comb begin
    if (a_nan && b_nan) minmax = 32'h7fc00000;  // Canonical NaN
    else if (a_nan)     minmax = opb;
    else if (b_nan)     minmax = opa;
    else if ((lt_raw || (both_zero && opa[31])) == x_ctrl.op.min) minmax = opa;
    else                minmax = opb;
  end

  always_comb begin
    logic is_neg;
    logic exp_max;
    logic exp_zero;
    logic man_zero;
    is_neg   = opa[31];
    exp_max  = (opa[30:23] == 8'hff);
    exp_zero = (opa[30:23] == 8'h00);
    man_zero = (opa[22:0] == '0);
    fclass[0] = is_neg && exp_max && man_zero;
    fclass[1] = is_neg && !exp_max && !exp_zero;
    fclass[2] = is_neg && exp_zero && !man_zero;
    fclass[3] = is_neg && exp_zero && man_zero;
    fclass[4] = !is_neg && exp_zero && man_zero;
    fclass[5] = !is_neg && exp_zero && !man_zero;
    fclass[6] = !is_neg && !exp_max && !exp_zero;
    fclass[7] = !is_neg && exp_max && man_zero;
    fclass[8] = a_nan && !opa[22];  // Signaling
    fclass[9] = a_nan && opa[22];
  end

  assign ok = x_ctrl.legal && x_ctrl.supported;

  always_comb begin
    w_next             = '0;
    w_next.valid       = x_valid;
    w_next.rd          = x_ctrl.rd;
    w_next.to_fp       = x_valid && ok && x_ctrl.fwren;
    w_next.to_int      = x_valid && ok && x_ctrl.wren;
    w_next.illegal     = x_valid && !x_ctrl.legal;
    w_next.unsupported = x_valid && x_ctrl.legal && !x_ctrl.supported;
    if (x_ctrl.op.sgnj)                      w_next.data = {opb[31], opa[30:0]};
    else if (x_ctrl.op.sgnjn)                w_next.data = {~opb[31], opa[30:0]};
    else if (x_ctrl.op.sgnjx)                w_next.data = {opa[31] ^ opb[31], opa[30:0]};
    else if (x_ctrl.op.min || x_ctrl.op.max) w_next.data = minmax;
    else if (x_ctrl.op.feq)                  w_next.data = {31'b0, feq};
    else if (x_ctrl.op.flt)                  w_next.data = {31'b0, flt};
    else if (x_ctrl.op.fle)                  w_next.data = {31'b0, flt || feq};
    else if (x_ctrl.op.fclass)               w_next.data = {22'b0, fclass};
    else if (x_ctrl.op.fmv_f2i)              w_next.data = opa;
    else if (x_ctrl.op.fmv_i2f)              w_next.data = x_ctrl.int_data;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) result_o <= '0;
    else          result_o <= w_next;
  end

  one_target: assert property (@(posedge clk) disable iff (!rst_n_i)
    result_o.valid |-> !(result_o.to_fp && result_o.to_int));

endmodule

// ==== source/fpu_regfile.sv ====
`timescale 1ns/100ps

module fpu_regfile (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic [2:0][4:0]   raddr_i,  // rs1 in slot 0
  output fpu_pkg::fp_rdata_s rd_o,
  input  logic              we_i,
  input  logic [4:0]        waddr_i,
  input  logic [31:0]       wdata_i
);

  logic [31:0]     mem [32];
  logic [2:0][4:0] raddr_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        mem[i] <= '0;
      end
      raddr_q <= '0;
    end else begin
      raddr_q <= raddr_i;
      if (we_i) mem[waddr_i] <= wdata_i;
    end
  end

  // Reads land one cycle after the address
  assign rd_o.rdata1 = mem[raddr_q[0]];
  assign rd_o.rdata2 = mem[raddr_q[1]];
  assign rd_o.rdata3 = mem[raddr_q[2]];

endmodule

// ==== source/fpu_decode.sv ====
`timescale 1ns/100ps

module fpu_decode (
  input  fpu_pkg::fp_req_s  instr_i,
  input  logic             valid_i,
  output fpu_pkg::fp_ctrl_s ctrl_o
);

  fpu_pkg::fp_instr_u instr;
  fpu_pkg::fp_op_s    op;
  logic [2:0] rm;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rs3;
  logic       frden1;
  logic       frden2;
  logic       frden3;
  logic       fwren;
  logic       wren;
  logic       legal;
  logic       supported;

  assign instr = instr_i.instr;
  assign rm    = instr.r.funct3;

  always_comb begin
    op        = '0;
    rd        = instr.r.rd;
    rs1       = instr.r.rs1;
    rs2       = instr.r.rs2;
    rs3       = '0;
    frden1    = 1'b0;
    frden2    = 1'b0;
    frden3    = 1'b0;
    fwren     = 1'b0;
    wren      = 1'b0;
    legal     = 1'b1;
    supported = 1'b0;
    case (instr.r.opcode)
      fpu_pkg::OPC_FLOAD: begin
        fwren = 1'b1;
        legal = (instr.r.funct3 == fpu_pkg::FUNCT3_W);
      end
      fpu_pkg::OPC_FSTORE: begin
        frden2 = 1'b1;
        legal  = (instr.r.funct3 == fpu_pkg::FUNCT3_W);
      end
      fpu_pkg::OPC_FP: begin
        case (instr.r.funct7[6:2])
          fpu_pkg::F7_FADD, fpu_pkg::F7_FSUB, fpu_pkg::F7_FMUL, fpu_pkg::F7_FDIV: begin
            fwren  = 1'b1;
            frden1 = 1'b1;
            frden2 = 1'b1;
          end
          fpu_pkg::F7_FSQRT: begin
            fwren  = 1'b1;
            frden1 = 1'b1;
          end
          fpu_pkg::F7_FSGNJ: begin
            fwren  = 1'b1;
            frden1 = 1'b1;
            frden2 = 1'b1;
            case (rm)
              3'd0:    op.sgnj  = 1'b1;
              3'd1:    op.sgnjn = 1'b1;
              3'd2:    op.sgnjx = 1'b1;
              default: legal    = 1'b0;
            endcase
            supported = legal;
          end
          fpu_pkg::F7_FMINMAX: begin
            fwren  = 1'b1;
            frden1 = 1'b1;
            frden2 = 1'b1;
            case (rm)
              3'd0:    op.min = 1'b1;
              3'd1:    op.max = 1'b1;
              default: legal  = 1'b0;
            endcase
            supported = legal;
          end
          fpu_pkg::F7_FCMP: begin
            wren   = 1'b1;
            frden1 = 1'b1;
            frden2 = 1'b1;
            case (rm)
              3'd0:    op.fle = 1'b1;
              3'd1:    op.flt = 1'b1;
              3'd2:    op.feq = 1'b1;
              default: legal  = 1'b0;
            endcase
            supported = legal;
          end
          fpu_pkg::F7_FMV_F2I: begin
            wren   = 1'b1;
            frden1 = 1'b1;
            case (rm)
              3'd0:    op.fmv_f2i = 1'b1;
              3'd1:    op.fclass  = 1'b1;
              default: legal      = 1'b0;
            endcase
            supported = legal;
          end
          fpu_pkg::F7_FMV_I2F: begin
            fwren      = 1'b1;
            op.fmv_i2f = 1'b1;
            supported  = 1'b1;
          end
          fpu_pkg::F7_FCVT_F2I: begin
            wren   = 1'b1;
            frden1 = 1'b1;
          end
          fpu_pkg::F7_FCVT_I2F: fwren = 1'b1;
          default:              legal = 1'b0;
        endcase
      end
      fpu_pkg::OPC_FMADD, fpu_pkg::OPC_FMSUB, fpu_pkg::OPC_FNMSUB, fpu_pkg::OPC_FNMADD: begin
        rs3    = instr.r4.rs3;  // rd, rs1 and rs2 sit where the r view has them
        fwren  = 1'b1;
        frden1 = 1'b1;
        frden2 = 1'b1;
        frden3 = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    ctrl_o.op        = valid_i ? op : '0;
    ctrl_o.rd        = rd;
    ctrl_o.rs1       = rs1;
    ctrl_o.rs2       = rs2;
    ctrl_o.rs3       = rs3;
    ctrl_o.frden1    = frden1 & valid_i;
    ctrl_o.frden2    = frden2 & valid_i;
    ctrl_o.frden3    = frden3 & valid_i;
    ctrl_o.fwren     = fwren & valid_i;
    ctrl_o.wren      = wren & valid_i;
    ctrl_o.legal     = legal;
    ctrl_o.supported = supported;
    ctrl_o.int_data  = instr_i.int_data;
  end

endmodule

// ==== source/fpu_issue_ctrl.sv ====
`timescale 1ns/100ps

module fpu_issue_ctrl (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            req_i,
  input  fpu_pkg::fp_req_s req_data_i,
  output logic            ack_o,
  output logic            issue_o,
  output fpu_pkg::fp_req_s issue_data_o
);

  typedef enum logic [1:0] {IDLE, CAPTURE, HOLD} state_e;

  state_e state;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (req_i) state <= CAPTURE;
        CAPTURE: state <= req_i ? HOLD : IDLE;
        HOLD:    if (!req_i) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && req_i) issue_data_o <= req_data_i;  // Request word is stable with req
  end

  assign ack_o   = (state != IDLE);
  assign issue_o = (state == CAPTURE);

  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(ack_o) |-> $past(req_i));

  issue_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    issue_o |=> !issue_o);

endmodule

// ==== source/fpu_pkg.sv ====
package fpu_pkg;

  // Major opcodes of the F extension
  localparam logic [6:0] OPC_FLOAD  = 7'b0000111;
  localparam logic [6:0] OPC_FSTORE = 7'b0100111;
  localparam logic [6:0] OPC_FP     = 7'b1010011;
  localparam logic [6:0] OPC_FMADD  = 7'b1000011;
  localparam logic [6:0] OPC_FMSUB  = 7'b1000111;
  localparam logic [6:0] OPC_FNMSUB = 7'b1001011;
  localparam logic [6:0] OPC_FNMADD = 7'b1001111;

  // Group codes in funct7[6:2] with fmt in funct7[1:0]
  localparam logic [4:0] F7_FADD     = 5'b00000;
  localparam logic [4:0] F7_FSUB     = 5'b00001;
  localparam logic [4:0] F7_FMUL     = 5'b00010;
  localparam logic [4:0] F7_FDIV     = 5'b00011;
  localparam logic [4:0] F7_FSQRT    = 5'b01011;
  localparam logic [4:0] F7_FSGNJ    = 5'b00100;
  localparam logic [4:0] F7_FMINMAX  = 5'b00101;
  localparam logic [4:0] F7_FCMP     = 5'b10100;
  localparam logic [4:0] F7_FMV_F2I  = 5'b11100;
  localparam logic [4:0] F7_FMV_I2F  = 5'b11110;
  localparam logic [4:0] F7_FCVT_F2I = 5'b11000;
  localparam logic [4:0] F7_FCVT_I2F = 5'b11010;

  localparam logic [2:0] FUNCT3_W = 3'b010;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [4:0] rs3;
      logic [1:0] fmt;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] rm;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r4;
  } fp_instr_u;

  typedef struct packed {
    logic sgnj;
    logic sgnjn;
    logic sgnjx;
    logic min;
    logic max;
    logic feq;
    logic flt;
    logic fle;
    logic fclass;
    logic fmv_f2i;
    logic fmv_i2f;
  } fp_op_s;

  typedef struct packed {
    fp_instr_u   instr;
    logic [31:0] int_data;  // Source of fmv.w.x
  } fp_req_s;

  typedef struct packed {
    fp_op_s      op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rs3;
    logic        frden1;
    logic        frden2;
    logic        frden3;
    logic        fwren;  // FP register file target
    logic        wren;   // Integer target
    logic        legal;
    logic        supported;
    logic [31:0] int_data;
  } fp_ctrl_s;

  typedef struct packed {
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] rdata3;
  } fp_rdata_s;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        to_fp;
    logic        to_int;
    logic        illegal;
    logic        unsupported;
  } fp_result_s;

endpackage
